// ==== Makefile ====
SRCS = $(shell cat cpu_fetch.f)

obj_dir/Vfetch_tb: cpu_fetch.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f cpu_fetch.f --top-module fetch_tb -o Vfetch_tb

run: obj_dir/Vfetch_tb
	./obj_dir/Vfetch_tb > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== cpu_fetch.f ====
src/fetch_pkg.sv
src/branch_predictor.sv
src/fetch_stage.sv
src/mem_arbiter.sv
src/unified_memory.sv
src/fetch_top.sv
testbench/clock_gen.sv
testbench/fetch_tb.sv

// ==== src/branch_predictor.sv ====
`timescale 1ns/1ns

module branch_predictor import fetch_pkg::*; #(
  parameter int bp_index_w = 4  // Table has 2**bp_index_w entries
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [addr_w-1:0] lookup_pc,    // PC being fetched
  output logic [1:0]        pred_ctr,     // Counter for lookup_pc
  output logic [addr_w-1:0] pred_target,  // Cached target for lookup_pc
  output logic              pred_hit,     // Target entry holds a real target
  input  logic              res_valid,    // A branch resolved in decode
  input  logic [addr_w-1:0] res_pc,       // PC of the resolved branch
  input  logic              res_taken,    // Actual direction
  input  logic [addr_w-1:0] res_target    // Actual target when taken
);

  localparam int n_entries = 2 ** bp_index_w;

  logic [1:0]        bht        [n_entries];  // Branch history table
  logic [addr_w-1:0] btb_target [n_entries];  // Branch target buffer payload
  logic [n_entries-1:0] btb_valid;            // One valid bit per target entry

  logic [bp_index_w-1:0] lk_idx;   // Index for the fetch side lookup
  logic [bp_index_w-1:0] upd_idx;  // Index for the resolution side update
  logic [1:0]            upd_ctr;  // Counter being trained
  logic [1:0]            upd_ctr_next;

  // Instructions are halfword aligned so bit 0 never carries information
  assign lk_idx  = lookup_pc[bp_index_w:1];
  assign upd_idx = res_pc[bp_index_w:1];

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  // Purely combinational so the fetch stage sees the prediction in the request cycle
  assign pred_ctr    = bht[lk_idx];
  assign pred_target = btb_target[lk_idx];
  assign pred_hit    = btb_valid[lk_idx];

  ////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////

  assign upd_ctr = bht[upd_idx];

  // Saturating two-bit counter, one step toward the actual outcome
  always_comb begin
    case (upd_ctr)
      ctr_strong_nt: upd_ctr_next = res_taken ? ctr_weak_nt  : ctr_strong_nt;
      ctr_weak_nt:   upd_ctr_next = res_taken ? ctr_weak_t   : ctr_strong_nt;
      ctr_weak_t:    upd_ctr_next = res_taken ? ctr_strong_t : ctr_weak_nt;
      default:       upd_ctr_next = res_taken ? ctr_strong_t : ctr_weak_t;  // Strong taken
    endcase
  end

  // Counters and valid bits are control state and come out of reset clean
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < n_entries; i++) begin
        bht[i] <= ctr_reset;
      end
      btb_valid <= '0;
    end else if (res_valid) begin
      bht[upd_idx] <= upd_ctr_next;
      if (res_taken) begin
        btb_valid[upd_idx] <= 1'b1;  // Target becomes usable once a taken branch was seen
      end
    end
  end

  // Target payload only matters once its valid bit is set
  always_ff @(posedge clk) begin
    if (res_valid && res_taken) begin
      btb_target[upd_idx] <= res_target;
    end
  end

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////

  localparam int addr_w = 16;  // Byte address width of the program counter and memory bus
  localparam int word_w = 16;  // One instruction or one data word

  ////////////////////////////////////////////////////////////
  // Branch history counter codes
  ////////////////////////////////////////////////////////////

  // Counter bit 1 is the taken prediction
  // Training moves one step per resolution and stops at either end
  localparam logic [1:0] ctr_strong_nt = 2'b00;
  localparam logic [1:0] ctr_weak_nt   = 2'b01;
  localparam logic [1:0] ctr_weak_t    = 2'b10;
  localparam logic [1:0] ctr_strong_t  = 2'b11;

  // A fresh entry leans not taken and needs one taken resolution to flip
  localparam logic [1:0] ctr_reset = ctr_weak_nt;

  ////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////

  localparam logic [addr_w-1:0] reset_pc = 16'h0000;  // First fetch address out of reset

endpackage

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import fetch_pkg::*; #(
  parameter int fetch_credits = 4,  // Buffer slots available in decode
  parameter int bp_index_w    = 4   // Passed through to the predictor
) (
  input  logic              clk,
  input  logic              rst,
  output logic              f_req,       // Memory request to the arbiter
  output logic [addr_w-1:0] f_addr,      // Fetch address
  input  logic              f_gnt,       // Request accepted this cycle
  input  logic              f_rvalid,    // Read data for the granted request
  input  logic [word_w-1:0] f_rdata,
  output logic              inst_valid,  // One instruction handed to decode
  output logic [word_w-1:0] inst,
  output logic [addr_w-1:0] inst_pc,
  output logic [1:0]        inst_pred,   // Counter the fetch was predicted with
  input  logic              credit_ret,  // Decode freed one slot
  input  logic              res_valid,
  input  logic [addr_w-1:0] res_pc,
  input  logic              res_taken,
  input  logic [addr_w-1:0] res_target,
  input  logic              res_mispredict
);

  localparam int credit_w = $clog2(fetch_credits + 1);

  logic [addr_w-1:0]   pc;
  logic [credit_w-1:0] credit_cnt;   // Slots left in decode
  logic                req_pend;     // Request raised and waiting for the grant
  logic                outstanding;  // Request granted and waiting for data
  logic                epoch;        // Flips on every redirect

  logic [addr_w-1:0] req_pc;     // PC of the granted request
  logic [1:0]        req_pred;   // Prediction of the granted request
  logic              req_epoch;  // Epoch the granted request was issued in

  logic [1:0]        pred_ctr;
  logic [addr_w-1:0] pred_target;
  logic              pred_hit;

  logic              redirect;   // Decode overrides the fetch path
  logic [addr_w-1:0] redirect_pc;
  logic [addr_w-1:0] next_pc;    // Predicted successor of pc
  logic              accept;     // Response survives the epoch check

  branch_predictor #(
    .bp_index_w(bp_index_w)
  ) u_bp (
    .clk        (clk),
    .rst        (rst),
    .lookup_pc  (pc),
    .pred_ctr   (pred_ctr),
    .pred_target(pred_target),
    .pred_hit   (pred_hit),
    .res_valid  (res_valid),
    .res_pc     (res_pc),
    .res_taken  (res_taken),
    .res_target (res_target)
  );

  ////////////////////////////////////////////////////////////
  // Next PC selection
  ////////////////////////////////////////////////////////////

  assign redirect    = res_valid && res_mispredict;
  assign redirect_pc = res_taken ? res_target : res_pc + addr_w'(2);
  assign next_pc     = (pred_ctr[1] && pred_hit) ? pred_target : pc + addr_w'(2);

  // A response in the redirect cycle belongs to the path being thrown away
  assign accept = f_rvalid && (req_epoch == epoch) && !redirect;

  assign f_req  = req_pend;
  assign f_addr = pc;  // PC only moves on a grant or a redirect

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= reset_pc;
      credit_cnt  <= credit_w'(fetch_credits);
      req_pend    <= 1'b0;
      outstanding <= 1'b0;
      epoch       <= 1'b0;
      req_epoch   <= 1'b0;
      inst_valid  <= 1'b0;
    end else begin
      inst_valid <= accept;  // Single cycle pulse per accepted instruction

      // Raise a request only when idle and decode has room
      if (!req_pend && !outstanding && credit_cnt != '0) begin
        req_pend <= 1'b1;
      end else if (f_gnt) begin
        req_pend    <= 1'b0;
        outstanding <= 1'b1;
        req_epoch   <= epoch;  // Old epoch if a redirect lands in this cycle
      end

      if (f_rvalid) begin
        outstanding <= 1'b0;  // Stale responses also free the slot
      end

      // Redirect wins over the predicted successor
      if (redirect) begin
        pc    <= redirect_pc;
        epoch <= ~epoch;
      end else if (f_gnt) begin
        pc <= next_pc;
      end

      // Credit spent on emit, returned by decode, never above the initial count
      if (accept && !credit_ret) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (!accept && credit_ret && credit_cnt != credit_w'(fetch_credits)) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Request payload and output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (f_gnt) begin
      req_pc   <= pc;        // Tag the request with where it came from
      req_pred <= pred_ctr;  // and what the predictor said about it
    end
    if (accept) begin
      inst      <= f_rdata;
      inst_pc   <= req_pc;
      inst_pred <= req_pred;
    end
  end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; #(
  parameter int fetch_credits  = 4,   // Decode buffer depth
  parameter int mem_depth_log2 = 10,  // 1K words of unified memory
  parameter int bp_index_w     = 4    // 16 predictor entries
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              d_req,        // External data port
  input  logic              d_we,
  input  logic [addr_w-1:0] d_addr,
  input  logic [word_w-1:0] d_wdata,
  output logic              d_gnt,
  output logic              d_rvalid,
  output logic [word_w-1:0] d_rdata,
  output logic              inst_valid,   // Toward decode
  output logic [word_w-1:0] inst,
  output logic [addr_w-1:0] inst_pc,
  output logic [1:0]        inst_pred,
  input  logic              credit_ret,
  input  logic              res_valid,    // Branch resolution from decode
  input  logic [addr_w-1:0] res_pc,
  input  logic              res_taken,
  input  logic [addr_w-1:0] res_target,
  input  logic              res_mispredict
);

  // Fetch side of the arbiter
  logic              f_req;
  logic [addr_w-1:0] f_addr;
  logic              f_gnt;
  logic              f_rvalid;
  logic [word_w-1:0] f_rdata;

  // Memory port
  logic              m_en;
  logic              m_we;
  logic [addr_w-1:0] m_addr;
  logic [word_w-1:0] m_wdata;
  logic [word_w-1:0] m_rdata;

  fetch_stage #(
    .fetch_credits(fetch_credits),
    .bp_index_w   (bp_index_w)
  ) u_fetch (
    .clk(clk), .rst(rst),
    .f_req(f_req), .f_addr(f_addr), .f_gnt(f_gnt),
    .f_rvalid(f_rvalid), .f_rdata(f_rdata),
    .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc), .inst_pred(inst_pred),
    .credit_ret(credit_ret),
    .res_valid(res_valid), .res_pc(res_pc), .res_taken(res_taken),
    .res_target(res_target), .res_mispredict(res_mispredict)
  );

  mem_arbiter u_arb (
    .clk(clk), .rst(rst),
    .f_req(f_req), .f_addr(f_addr), .f_gnt(f_gnt),
    .f_rvalid(f_rvalid), .f_rdata(f_rdata),
    .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
    .d_gnt(d_gnt), .d_rvalid(d_rvalid), .d_rdata(d_rdata),
    .m_en(m_en), .m_we(m_we), .m_addr(m_addr), .m_wdata(m_wdata), .m_rdata(m_rdata)
  );

  unified_memory #(
    .mem_depth_log2(mem_depth_log2)
  ) u_mem (
    .clk(clk),
    .m_en(m_en), .m_we(m_we), .m_addr(m_addr), .m_wdata(m_wdata), .m_rdata(m_rdata)
  );

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              f_req,     // Fetch requester, always a read
  input  logic [addr_w-1:0] f_addr,
  output logic              f_gnt,
  output logic              f_rvalid,
  output logic [word_w-1:0] f_rdata,
  input  logic              d_req,     // Data requester, read or write
  input  logic              d_we,
  input  logic [addr_w-1:0] d_addr,
  input  logic [word_w-1:0] d_wdata,
  output logic              d_gnt,
  output logic              d_rvalid,
  output logic [word_w-1:0] d_rdata,
  output logic              m_en,      // Single memory port
  output logic              m_we,
  output logic [addr_w-1:0] m_addr,
  output logic [word_w-1:0] m_wdata,
  input  logic [word_w-1:0] m_rdata
);

  logic f_owner;     // Fetch read was granted last cycle
  logic d_rd_owner;  // Data read was granted last cycle

  ////////////////////////////////////////////////////////////
  // Grant, data port has priority
  ////////////////////////////////////////////////////////////

  assign d_gnt = d_req;
  assign f_gnt = f_req && !d_req;  // Fetch only gets the idle slots

  // Steer the winner onto the memory port
  assign m_en    = d_req || f_req;
  assign m_we    = d_req && d_we;
  assign m_addr  = d_req ? d_addr : f_addr;
  assign m_wdata = d_wdata;  // Fetch never writes

  ////////////////////////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////////////////////////

  // Remember the winner for the one cycle of read latency
  always_ff @(posedge clk) begin
    if (rst) begin
      f_owner    <= 1'b0;
      d_rd_owner <= 1'b0;
    end else begin
      f_owner    <= f_gnt;
      d_rd_owner <= d_req && !d_we;  // A write gets no response
    end
  end

  assign f_rvalid = f_owner;
  assign d_rvalid = d_rd_owner;
  assign f_rdata  = m_rdata;  // Shared read bus, the valid strobes tell them apart
  assign d_rdata  = m_rdata;

endmodule

// ==== src/unified_memory.sv ====
`timescale 1ns/1ns

module unified_memory import fetch_pkg::*; #(
  parameter int mem_depth_log2 = 10  // Number of words as a power of two
) (
  input  logic              clk,
  input  logic              m_en,     // Access this cycle
  input  logic              m_we,     // Write when set, read otherwise
  input  logic [addr_w-1:0] m_addr,   // Byte address
  input  logic [word_w-1:0] m_wdata,
  output logic [word_w-1:0] m_rdata   // Valid the cycle after the access
);

  localparam int depth = 2 ** mem_depth_log2;

  logic [word_w-1:0]         mem [depth];  // Program and data share this array
  logic [mem_depth_log2-1:0] word_idx;

  // Drop the byte offset and fold out the upper address bits
  assign word_idx = m_addr[mem_depth_log2:1];

  ////////////////////////////////////////////////////////////
  // Single port with registered read
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (m_en) begin
      if (m_we) begin
        mem[word_idx] <= m_wdata;
      end
      // Nonblocking read samples the array before the write lands, so old data comes back
      m_rdata <= mem[word_idx];
    end
  end

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // Reset spans the first eight rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

  localparam int credits   = 4;
  localparam int prog_words = 512;  // Program fills the lower half of memory

  logic clk, rst;
  logic d_req = 1'b0, d_we = 1'b0;
  logic [15:0] d_addr = '0, d_wdata = '0;
  logic d_gnt, d_rvalid, inst_valid;
  logic [15:0] d_rdata, inst, inst_pc;
  logic [1:0] inst_pred;
  logic credit_ret = 1'b0;  // Driven by the decode model in the compare process
  logic res_valid = 1'b0, res_taken = 1'b0, res_mispredict = 1'b0;
  logic [15:0] res_pc = '0, res_target = '0;

  // Reference predictor state indexed like the DUT by pc[4:1]
  logic [1:0]  m_ctr [16];
  logic [15:0] m_tgt [16];
  logic        m_vld [16];
  logic [15:0] exp_pc;             // Next PC the stream should deliver
  logic [15:0] last_pc = '0;
  logic [1:0]  last_pred = '0;
  int held = 0;                    // Instructions decode holds without a returned credit
  int quiet = 0;                   // Cycles since the last inst_valid
  int n_inst = 0;
  int checks = 0;
  int errors = 0;
  logic auto_credit = 1'b0;        // Decode frees slots as fast as it can
  logic give_one = 1'b0;           // Return a single credit

  clock_gen clkgen (.clk(clk), .rst(rst));

  fetch_top #(.fetch_credits(credits)) UUT (
    .clk(clk), .rst(rst),
    .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
    .d_gnt(d_gnt), .d_rvalid(d_rvalid), .d_rdata(d_rdata),
    .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc), .inst_pred(inst_pred),
    .credit_ret(credit_ret),
    .res_valid(res_valid), .res_pc(res_pc), .res_taken(res_taken),
    .res_target(res_target), .res_mispredict(res_mispredict)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Every bit of the address shapes the word
  function automatic logic [15:0] prog_word(input logic [15:0] a);
    return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'h5a3c;
  endfunction

  // A taken counter with a known target jumps and anything else falls through to PC+2
  function automatic logic [15:0] ref_next(input logic [15:0] pc);
    logic [3:0] i;
    i = pc[4:1];
    if (m_ctr[i][1] && m_vld[i]) return m_tgt[i];
    return pc + 16'd2;
  endfunction

  task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] expv);
    checks++;
    assert (got == expv) else begin
      $display("[ERROR] %s got %h expected %h", name, got, expv);
      errors++;
    end
  endtask

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process and decode model
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    int held_now;
    logic [3:0] ri;
    if (rst) begin
      exp_pc = reset_pc;
      held = 0;
      credit_ret <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        m_ctr[i] = ctr_reset;
        m_vld[i] = 1'b0;
        m_tgt[i] = '0;
      end
    end else begin
      held_now = held;
      quiet = quiet + 1;
      if (inst_valid) begin  // Values seen here were registered on the previous edge
        check_eq("inst_pc", inst_pc, exp_pc);
        check_eq("inst", inst, prog_word(exp_pc));
        check_eq("inst_pred", 16'(inst_pred), 16'(m_ctr[exp_pc[4:1]]));
        last_pc = inst_pc;
        last_pred = inst_pred;
        n_inst++;
        quiet = 0;
        held_now++;
        exp_pc = ref_next(exp_pc);
      end
      if (res_valid) begin  // The DUT trains on this same edge
        ri = res_pc[4:1];
        if (res_taken) begin
          if (m_ctr[ri] != 2'b11) m_ctr[ri] = m_ctr[ri] + 2'd1;
          m_tgt[ri] = res_target;
          m_vld[ri] = 1'b1;
        end else if (m_ctr[ri] != 2'b00) begin
          m_ctr[ri] = m_ctr[ri] - 2'd1;
        end
        if (res_mispredict) exp_pc = res_taken ? res_target : res_pc + 16'd2;
      end
      if ((auto_credit || give_one) && held_now > 0) begin
        credit_ret <= 1'b1;
        held = held_now - 1;
        give_one = 1'b0;
      end else begin
        credit_ret <= 1'b0;
        held = held_now;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic wait_insts(input int n, input string what);
    int target;
    int t;
    target = n_inst + n;
    t = 0;
    while (n_inst < target) begin
      @(negedge clk);
      t++;
      if (t > 2000) give_up(what);
    end
  endtask

  // Decode stops returning credits and the stream must run dry
  task automatic wait_quiet();
    int t;
    @(negedge clk);
    auto_credit = 1'b0;
    t = 0;
    while (quiet < 50) begin
      @(negedge clk);
      t++;
      if (t > 1000) give_up("the fetch stream to stall");
    end
  endtask

  task automatic wait_pc(input logic [15:0] pc);
    int n0;
    int t;
    n0 = n_inst;
    t = 0;
    while (!(n_inst > n0 && last_pc == pc)) begin
      @(negedge clk);
      t++;
      if (t > 2000) give_up("a fetch at the watched PC");
    end
  endtask

  task automatic resolve(input logic [15:0] pc, input logic taken, input logic [15:0] tgt,
                         input logic mis);
    @(posedge clk);
    res_valid <= 1'b1;
    res_pc <= pc;
    res_taken <= taken;
    res_target <= tgt;
    res_mispredict <= mis;
    @(posedge clk);
    res_valid <= 1'b0;
    res_mispredict <= 1'b0;
  endtask

  task automatic data_write(input logic [15:0] a, input logic [15:0] d);
    @(posedge clk);
    d_req <= 1'b1;
    d_we <= 1'b1;
    d_addr <= a;
    d_wdata <= d;
    @(negedge clk);
    check_eq("d_gnt", 16'(d_gnt), 16'd1);  // Data port always wins the slot
    @(posedge clk);
    d_req <= 1'b0;
    d_we <= 1'b0;
    @(negedge clk);
    check_eq("d_rvalid", 16'(d_rvalid), 16'd0);  // A write has no read response
  endtask

  task automatic data_read(input logic [15:0] a, input logic [15:0] expv);
    int t;
    @(posedge clk);
    d_req <= 1'b1;
    d_we <= 1'b0;
    d_addr <= a;
    @(negedge clk);
    check_eq("d_gnt", 16'(d_gnt), 16'd1);
    @(posedge clk);
    d_req <= 1'b0;
    t = 0;
    @(negedge clk);
    while (!d_rvalid) begin
      if (t > 10) give_up("d_rvalid");
      @(negedge clk);
      t++;
    end
    check_eq("d_rdata", d_rdata, expv);
  endtask

  task automatic report(input string name, input int err_before);
    $display("test %-28s %s", name, (errors == err_before) ? "pass" : "fail");
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int e0;
    int n0;
    logic [15:0] x, tg, a, dv;
    void'($urandom(5));

    // Preload back to back from inside reset so fetch never wins the port early
    @(posedge clk);
    for (int i = 0; i < prog_words; i++) begin
      d_req <= 1'b1;
      d_we <= 1'b1;
      d_addr <= 16'(i * 2);
      d_wdata <= prog_word(16'(i * 2));
      @(posedge clk);
    end
    d_req <= 1'b0;
    d_we <= 1'b0;

    e0 = errors;
    @(negedge clk);
    auto_credit = 1'b1;
    wait_insts(16, "sequential fetch");
    report("sequential fetch", e0);

    e0 = errors;
    wait_quiet();
    check_eq("held credits", 16'(held), 16'(credits));
    n0 = n_inst;
    give_one = 1'b1;  // One slot back releases one instruction
    wait_insts(1, "fetch after one credit");
    wait_quiet();
    check_eq("instructions after one credit", 16'(n_inst - n0), 16'd1);
    report("credit back-pressure", e0);

    e0 = errors;
    x = exp_pc + 16'd6;
    tg = x + 16'h22;
    resolve(x, 1'b1, tg, 1'b0);
    @(negedge clk);
    auto_credit = 1'b1;
    wait_pc(x);
    check_eq("inst_pred at branch", 16'(last_pred), 16'(ctr_weak_t));
    wait_insts(1, "fetch after taken branch");
    check_eq("inst_pc after branch", last_pc, tg);
    wait_quiet();
    resolve(x, 1'b0, 16'h0000, 1'b0);
    resolve(x, 1'b0, 16'h0000, 1'b0);
    resolve(x - 16'd2, 1'b0, 16'h0000, 1'b1);  // Steer fetch back onto the branch
    @(negedge clk);
    auto_credit = 1'b1;
    wait_pc(x);
    wait_insts(1, "fetch after untrained branch");
    check_eq("inst_pc after untrained branch", last_pc, x + 16'd2);
    report("branch prediction", e0);

    // Redirects land at varying points of the request in flight
    e0 = errors;
    for (int k = 0; k < 4; k++) begin
      wait_insts(2 + k, "fetch before redirect");
      tg = last_pc + 16'h18 + 16'(2 * k);
      resolve(tg, 1'b0, 16'h0000, 1'b1);
      wait_pc(tg + 16'd2);
    end
    report("mispredict redirect", e0);

    // Data traffic stays in the upper half away from the program
    e0 = errors;
    for (int k = 0; k < 24; k++) begin
      a = 16'h0400 + 16'(($urandom % 256) * 2);
      dv = 16'($urandom);
      data_write(a, dv);
      repeat ($urandom % 3) @(posedge clk);
      data_read(a, dv);
    end
    wait_insts(8, "fetch after data traffic");
    report("data port traffic", e0);

    $display("checks %0d errors %0d instructions %0d", checks, errors, n_inst);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
